// File: pkt_pkg.sv
// shared types and constants for the two-channel packet bridge, imported by every RTL module
package pkt_pkg;

    // channel count and link width
    localparam int num_chan = 2;
    localparam int data_w   = 32;

    // header field widths, must add up to data_w
    localparam int magic_w  = 16;
    localparam int chan_w   = 4;
    localparam int seq_w    = 12;

    // apb address width and packet counter width
    localparam int addr_w   = 8;
    localparam int cnt_w    = 16;

    // register map
    localparam logic [addr_w-1:0] reg_ctrl  = 8'h00;
    localparam logic [addr_w-1:0] reg_magic = 8'h04;
    localparam logic [addr_w-1:0] reg_cnt0  = 8'h08;
    localparam logic [addr_w-1:0] reg_cnt1  = 8'h0C;

    // reset value of the header magic
    localparam logic [magic_w-1:0] magic_rst = 16'hCAFE;

    // framer fsm encoding
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_head    = 2'd1;
    localparam logic [1:0] st_payload = 2'd2;

    // one beat on the framer-to-arbiter path and on the outbound link
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              sop;
        logic              eop;
        logic              chan;
    } link_beat_t;

    // header fields, msb first
    typedef struct packed {
        logic [magic_w-1:0] magic;
        logic [chan_w-1:0]  chan_id;
        logic [seq_w-1:0]   seq;
    } pkt_header_t;

    // header word, seen as a raw link word or as its fields
    typedef union packed {
        logic [data_w-1:0] raw;
        pkt_header_t       f;
    } pkt_header_u;

    // apb request, master to slave
    typedef struct packed {
        logic [addr_w-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    // apb response, slave to master
    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// File: pkt_framer.sv
// one channel framer: accepts a payload word and emits a header beat then a payload beat
`timescale 1ns/1ps

module pkt_framer import pkt_pkg::*; #(
    parameter int chan_idx = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [data_w-1:0]  in_data,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic               chan_en,
    input  logic [magic_w-1:0] magic,
    output link_beat_t         req_beat,
    output logic               req_valid,
    input  logic               beat_ready
);

    logic [1:0]         state_q;
    logic [seq_w-1:0]   seq_q;
    logic [data_w-1:0]  data_q;
    logic [magic_w-1:0] magic_q;
    logic               accept;
    logic               beat_xfer;
    pkt_header_u        hdr;

    // a new word only when idle and enabled
    assign in_ready  = (state_q == st_idle) && chan_en;
    assign accept    = in_valid && in_ready;
    assign req_valid = (state_q != st_idle);
    assign beat_xfer = req_valid && beat_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            seq_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= st_head;
                    end
                end
                st_head: begin
                    if (beat_xfer) begin
                        state_q <= st_payload;
                    end
                end
                st_payload: begin
                    if (beat_xfer) begin
                        state_q <= st_idle;
                        // 12-bit sequence wraps on its own
                        seq_q   <= seq_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // payload and magic held for the whole packet
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q  <= in_data;
            magic_q <= magic;
        end
    end

    // header built field by field
    always_comb begin
        hdr.f.magic   = magic_q;
        hdr.f.chan_id = chan_w'(chan_idx);
        hdr.f.seq     = seq_q;
    end

    always_comb begin
        req_beat.chan = 1'(chan_idx);
        req_beat.sop  = (state_q == st_head);
        req_beat.eop  = (state_q == st_payload);
        if (state_q == st_head) begin
            req_beat.data = hdr.raw;
        end else begin
            req_beat.data = data_q;
        end
    end

    // a stalled beat must not change under the arbiter
    a_beat_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_valid && !beat_ready) |=> (req_valid && $stable(req_beat))
    ) else $error("framer %0d changed a stalled beat", chan_idx);

endmodule

// File: link_arbiter.sv
// packet-atomic round-robin arbiter that puts framer beats onto the single outbound link
`timescale 1ns/1ps

module link_arbiter import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  link_beat_t          req_beat [num_chan],
    input  logic [num_chan-1:0] req_valid,
    output logic [num_chan-1:0] beat_ready,
    output link_beat_t          link_beat,
    output logic                link_valid,
    input  logic                link_ready
);

    logic                prio_q;
    logic                locked_q;
    logic                lock_chan_q;
    logic                gnt_idx;
    logic [num_chan-1:0] grant;
    logic                link_xfer;

    // locked channel first, then the priority holder, then the other one
    always_comb begin
        if (locked_q) begin
            gnt_idx = lock_chan_q;
        end else if (req_valid[prio_q]) begin
            gnt_idx = prio_q;
        end else begin
            gnt_idx = ~prio_q;
        end
        if (req_valid[gnt_idx]) begin
            grant = num_chan'(1) << gnt_idx;
        end else begin
            grant = '0;
        end
    end

    assign link_valid = |grant;
    assign link_beat  = req_beat[gnt_idx];
    assign beat_ready = grant & {num_chan{link_ready}};
    assign link_xfer  = link_valid && link_ready;

    // the lock is taken as soon as a beat is offered, so a stalled
    // header cannot lose its grant to a later requester
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q      <= 1'b0;
            locked_q    <= 1'b0;
            lock_chan_q <= 1'b0;
        end else if (link_valid) begin
            lock_chan_q <= gnt_idx;
            if (link_xfer && link_beat.eop) begin
                locked_q <= 1'b0;
                prio_q   <= ~gnt_idx;
            end else begin
                locked_q <= 1'b1;
            end
        end
    end

    // while a packet is open the locked channel alone holds the grant
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        locked_q |-> (grant == (num_chan'(1) << lock_chan_q))
    ) else $error("arbiter grant not held one-hot on the locked channel");

    // no beat of another channel slips into a locked packet
    a_locked_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        (locked_q && link_xfer) |-> (link_beat.chan == lock_chan_q)
    ) else $error("beat from unlocked channel during a packet");

endmodule

// File: pkt_apb_regs.sv
// APB register block for channel enables, header magic and per-channel packet counters
`timescale 1ns/1ps

module pkt_apb_regs import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_req_t            apb_req,
    output apb_rsp_t            apb_rsp,
    input  link_beat_t          link_beat,
    input  logic                link_valid,
    input  logic                link_ready,
    output logic [num_chan-1:0] chan_en,
    output logic [magic_w-1:0]  magic
);

    logic                access;
    logic                wr_en;
    logic                addr_hit;
    logic                eop_xfer;
    logic [cnt_w-1:0]    cnt_q [num_chan];
    logic [num_chan-1:0] cnt_clr;
    logic [num_chan-1:0] cnt_inc;

    // no wait states, so setup plus enable is the whole access
    assign access   = apb_req.psel && apb_req.penable;
    assign addr_hit = (apb_req.paddr == reg_ctrl)  || (apb_req.paddr == reg_magic) ||
                      (apb_req.paddr == reg_cnt0)  || (apb_req.paddr == reg_cnt1);
    assign wr_en    = access && apb_req.pwrite && addr_hit;
    assign eop_xfer = link_valid && link_ready && link_beat.eop;

    always_comb begin
        cnt_clr[0] = wr_en && (apb_req.paddr == reg_cnt0);
        cnt_clr[1] = wr_en && (apb_req.paddr == reg_cnt1);
        for (int i = 0; i < num_chan; i++) begin
            cnt_inc[i] = eop_xfer && (link_beat.chan == 1'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_en <= '0;
            magic   <= magic_rst;
        end else if (wr_en) begin
            if (apb_req.paddr == reg_ctrl) begin
                chan_en <= apb_req.pwdata[num_chan-1:0];
            end
            if (apb_req.paddr == reg_magic) begin
                magic <= apb_req.pwdata[magic_w-1:0];
            end
        end
    end

    // clear wins over a same-cycle increment, counts saturate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_chan; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_inc[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && !addr_hit;
        case (apb_req.paddr)
            reg_ctrl:  apb_rsp.prdata = data_w'(chan_en);
            reg_magic: apb_rsp.prdata = data_w'(magic);
            reg_cnt0:  apb_rsp.prdata = data_w'(cnt_q[0]);
            reg_cnt1:  apb_rsp.prdata = data_w'(cnt_q[1]);
            default:   apb_rsp.prdata = '0;
        endcase
    end

    // enable phase only after a setup phase
    a_apb_phase: assert property (
        @(posedge clk) disable iff (!rst_n)
        apb_req.penable |-> $past(apb_req.psel && !apb_req.penable)
    ) else $error("apb penable without a preceding setup phase");

endmodule

// File: pkt_bridge_top.sv
// top level of the packet bridge: two framers, the link arbiter and the APB register block
`timescale 1ns/1ps

module pkt_bridge_top import pkt_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  apb_req_t            apb_req,
    output apb_rsp_t            apb_rsp,
    input  logic [data_w-1:0]   in_data [num_chan],
    input  logic [num_chan-1:0] in_valid,
    output logic [num_chan-1:0] in_ready,
    output link_beat_t          link_beat,
    output logic                link_valid,
    input  logic                link_ready
);

    logic [num_chan-1:0] chan_en;
    logic [magic_w-1:0]  magic;
    link_beat_t          req_beat [num_chan];
    logic [num_chan-1:0] req_valid;
    logic [num_chan-1:0] beat_ready;

    pkt_framer #(.chan_idx(0)) u_framer0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data    (in_data[0]),
        .in_valid   (in_valid[0]),
        .in_ready   (in_ready[0]),
        .chan_en    (chan_en[0]),
        .magic      (magic),
        .req_beat   (req_beat[0]),
        .req_valid  (req_valid[0]),
        .beat_ready (beat_ready[0])
    );

    pkt_framer #(.chan_idx(1)) u_framer1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data    (in_data[1]),
        .in_valid   (in_valid[1]),
        .in_ready   (in_ready[1]),
        .chan_en    (chan_en[1]),
        .magic      (magic),
        .req_beat   (req_beat[1]),
        .req_valid  (req_valid[1]),
        .beat_ready (beat_ready[1])
    );

    link_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_beat   (req_beat),
        .req_valid  (req_valid),
        .beat_ready (beat_ready),
        .link_beat  (link_beat),
        .link_valid (link_valid),
        .link_ready (link_ready)
    );

    // counters watch the same handshake the link sees
    pkt_apb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .link_beat  (link_beat),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .chan_en    (chan_en),
        .magic      (magic)
    );

endmodule

// File: tb_pkt_bridge.sv
// self-checking testbench for the packet bridge, run with flist.f and tb_pkt_bridge as top
`timescale 1ns/1ps

module tb_pkt_bridge import pkt_pkg::*; ();

    logic                      clk;
    logic                      rst_n;
    apb_req_t                  apb_req;
    apb_rsp_t                  apb_rsp;
    logic [data_w-1:0]         in_data [num_chan];
    logic [num_chan-1:0]       in_valid;
    logic [num_chan-1:0]       in_ready;
    link_beat_t                link_beat;
    logic                      link_valid;
    logic                      link_ready;

    // reference model state
    string                     test_name;
    integer                    seed;
    integer                    cycles;
    logic                      bp_on;
    logic [num_chan-1:0]       model_en;
    logic [magic_w-1:0]        model_magic;
    logic [seq_w-1:0]          model_seq [num_chan];
    logic [cnt_w-1:0]          model_cnt [num_chan];
    logic [magic_w+data_w-1:0] exp_q0 [$];
    logic [magic_w+data_w-1:0] exp_q1 [$];
    logic [num_chan-1:0]       exp_valid;
    logic [data_w-1:0]         exp_data [num_chan];
    logic [magic_w-1:0]        exp_magic [num_chan];
    logic                      open_pkt;
    logic                      open_chan;
    logic [data_w-1:0]         rd_exp;
    logic                      err_exp;

    // expectations for the channel currently on the link
    logic                      xfer;
    logic                      cur_valid;
    logic [data_w-1:0]         cur_data;
    logic [magic_w-1:0]        cur_magic;
    logic [seq_w-1:0]          cur_seq;
    pkt_header_u               hdr_seen;

    pkt_bridge_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .link_beat  (link_beat),
        .link_valid (link_valid),
        .link_ready (link_ready)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
        abort_run();
    endtask

    task automatic broken(input string what);
        $display("%s failed: %s", test_name, what);
        abort_run();
    endtask

    // one apb write, setup then access, model follows at the access edge
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.pwdata  <= data;
        err_exp         <= err;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        if (!err) begin
            case (addr)
                reg_ctrl:  model_en     <= data[num_chan-1:0];
                reg_magic: model_magic  <= data[magic_w-1:0];
                reg_cnt0:  model_cnt[0] <= '0;
                reg_cnt1:  model_cnt[1] <= '0;
                default: begin
                end
            endcase
        end
    endtask

    // read data and pslverr are checked by assertions during the access phase
    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input logic err);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        rd_exp          <= exp;
        err_exp         <= err;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic feed_words(input int c, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            in_valid[c] <= 1'b1;
            in_data[c]  <= $random(seed);
            do begin
                @(posedge clk);
            end while (!in_ready[c]);
            in_valid[c] <= 1'b0;
        end
    endtask

    // until every accepted word has left on the link
    task automatic wait_drained();
        do begin
            @(posedge clk);
        end while ((exp_q0.size() != 0) || (exp_q1.size() != 0) || link_valid);
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (bp_on) begin
            link_ready <= 1'($random(seed));
        end else begin
            link_ready <= 1'b1;
        end
    end

    // limit is about twice the longest run under back-pressure
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: run did not finish within %0d cycles in %s", cycles, test_name);
            abort_run();
        end
    end

    // model update from the input and link handshakes
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid[0] && in_ready[0]) begin
                exp_q0.push_back({model_magic, in_data[0]});
            end
            if (in_valid[1] && in_ready[1]) begin
                exp_q1.push_back({model_magic, in_data[1]});
            end
            if (link_valid && link_ready) begin
                if (link_beat.sop) begin
                    open_pkt  <= 1'b1;
                    open_chan <= link_beat.chan;
                end
                if (link_beat.eop) begin
                    open_pkt <= 1'b0;
                    model_seq[link_beat.chan] <= model_seq[link_beat.chan] + 1'b1;
                    model_cnt[link_beat.chan] <= model_cnt[link_beat.chan] + 1'b1;
                    if (!link_beat.chan && (exp_q0.size() != 0)) begin
                        void'(exp_q0.pop_front());
                    end else if (link_beat.chan && (exp_q1.size() != 0)) begin
                        void'(exp_q1.pop_front());
                    end
                end
            end
            exp_valid[0] <= (exp_q0.size() != 0);
            exp_valid[1] <= (exp_q1.size() != 0);
            if (exp_q0.size() != 0) begin
                {exp_magic[0], exp_data[0]} <= exp_q0[0];
            end
            if (exp_q1.size() != 0) begin
                {exp_magic[1], exp_data[1]} <= exp_q1[0];
            end
        end
    end

    assign xfer         = link_valid && link_ready;
    assign hdr_seen.raw = link_beat.data;

    always_comb begin
        cur_valid = exp_valid[link_beat.chan];
        cur_data  = exp_data[link_beat.chan];
        cur_magic = exp_magic[link_beat.chan];
        cur_seq   = model_seq[link_beat.chan];
    end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> (!link_valid && (in_ready == '0) && !apb_rsp.pslverr)
    ) else broken("outputs not idle after reset");

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
    ) else mismatch("pready", 1, $sampled(apb_rsp.pready));

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable) |-> (apb_rsp.pslverr == err_exp)
    ) else mismatch("pslverr", $sampled(err_exp), $sampled(apb_rsp.pslverr));

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_req.psel && apb_req.penable && !apb_req.pwrite) |-> (apb_rsp.prdata == rd_exp)
    ) else mismatch("read data", $sampled(rd_exp), $sampled(apb_rsp.prdata));

    a_hdr_magic: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && link_beat.sop) |-> (hdr_seen.f.magic == cur_magic)
    ) else mismatch("header magic", $sampled(cur_magic), $sampled(hdr_seen.f.magic));

    a_hdr_chan: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && link_beat.sop) |-> (hdr_seen.f.chan_id == {3'b000, link_beat.chan})
    ) else mismatch("header chan_id", $sampled(link_beat.chan), $sampled(hdr_seen.f.chan_id));

    a_hdr_seq: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && link_beat.sop) |-> (hdr_seen.f.seq == cur_seq)
    ) else mismatch("header seq", $sampled(cur_seq), $sampled(hdr_seen.f.seq));

    a_payload_known: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && link_beat.eop) |-> cur_valid
    ) else broken("payload beat with no accepted word left for its channel");

    a_payload_data: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && link_beat.eop) |-> (link_beat.data == cur_data)
    ) else mismatch("payload", $sampled(cur_data), $sampled(link_beat.data));

    a_sop_first: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && !open_pkt) |-> (link_beat.sop && !link_beat.eop)
    ) else broken("first beat of a packet is not a header");

    a_eop_second: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && open_pkt) |-> (link_beat.eop && !link_beat.sop)
    ) else broken("beat after a header is not the payload beat");

    a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && open_pkt) |-> (link_beat.chan == open_chan)
    ) else mismatch("packet channel", $sampled(open_chan), $sampled(link_beat.chan));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (link_valid && !link_ready) |=> (link_valid && $stable(link_beat))
    ) else broken("link beat changed or dropped while link_ready was low");

    a_ready_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (in_ready & ~model_en) == '0
    ) else mismatch("in_ready of disabled channel", 0, $sampled(in_ready & ~model_en));

    a_disabled_sop: assert property (@(posedge clk) disable iff (!rst_n)
        (link_valid && link_beat.sop) |-> model_en[link_beat.chan]
    ) else broken("packet header from a disabled channel on the link");

    initial begin
        seed        = 21;
        cycles      = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        in_data[0]  = '0;
        in_data[1]  = '0;
        in_valid    = '0;
        link_ready  = 1'b1;
        bp_on       = 1'b0;
        model_en    = '0;
        model_magic = magic_rst;
        exp_valid   = '0;
        open_pkt    = 1'b0;
        open_chan   = 1'b0;
        rd_exp      = '0;
        err_exp     = 1'b0;
        for (int i = 0; i < num_chan; i++) begin
            model_seq[i] = '0;
            model_cnt[i] = '0;
            exp_data[i]  = '0;
            exp_magic[i] = '0;
        end
        test_name = "reset_regs";
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        read_reg(reg_magic, 32'h0000_CAFE, 1'b0);
        write_reg(reg_magic, 32'h0000_5A3C, 1'b0);
        read_reg(reg_magic, 32'h0000_5A3C, 1'b0);
        write_reg(reg_ctrl, 32'h0000_0002, 1'b0);
        read_reg(reg_ctrl, 32'h0000_0002, 1'b0);
        // unmapped offsets flag an error and leave the registers alone
        write_reg(8'h14, 32'hFFFF_FFFF, 1'b1);
        read_reg(8'h10, 32'h0, 1'b1);
        read_reg(reg_magic, 32'h0000_5A3C, 1'b0);

        test_name = "single_packet";
        write_reg(reg_ctrl, 32'h0000_0001, 1'b0);
        feed_words(0, 1);
        wait_drained();

        test_name = "two_channel";
        write_reg(reg_ctrl, 32'h0000_0003, 1'b0);
        fork
            feed_words(0, 12);
            feed_words(1, 12);
        join
        wait_drained();

        test_name = "backpressure";
        bp_on <= 1'b1;
        fork
            feed_words(0, 16);
            feed_words(1, 16);
        join
        wait_drained();
        bp_on <= 1'b0;

        test_name = "counters";
        read_reg(reg_cnt0, data_w'(model_cnt[0]), 1'b0);
        read_reg(reg_cnt1, data_w'(model_cnt[1]), 1'b0);
        write_reg(reg_cnt0, 32'h0, 1'b0);
        read_reg(reg_cnt0, 32'h0, 1'b0);
        write_reg(reg_cnt1, 32'h0, 1'b0);
        read_reg(reg_cnt1, 32'h0, 1'b0);

        // channel 1 offers a word the whole time but stays disabled
        test_name = "enable_gating";
        write_reg(reg_ctrl, 32'h0000_0001, 1'b0);
        @(posedge clk);
        in_valid[1] <= 1'b1;
        in_data[1]  <= 32'hDEAD_BEEF;
        feed_words(0, 6);
        wait_drained();
        in_valid[1] <= 1'b0;
        read_reg(reg_cnt1, 32'h0, 1'b0);
        repeat (2) @(posedge clk);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: flist.f
pkt_pkg.sv
pkt_framer.sv
link_arbiter.sv
pkt_apb_regs.sv
pkt_bridge_top.sv
tb_pkt_bridge.sv
